// File: rtl/coreSequencer.sv
`timescale 1ns/1ps

module coreSequencer (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            halt,
    output tenyrPkg::word_t instrAddr,
    input  tenyrPkg::word_t instrData,
    output logic            dataStrobe,
    output logic            dataWrite,
    output tenyrPkg::word_t dataAddr,
    input  tenyrPkg::word_t dataIn,
    output tenyrPkg::word_t dataOut,
    output logic            storeValid,
    input  logic            storeReady,
    output tenyrPkg::word_t storeAddr,
    output tenyrPkg::word_t storeData
);

    typedef enum logic [2:0] {
        fetchWait,
        issue,
        execute,
        settle,
        memory,
        writeback,
        advance
    } state_t;

    state_t            state;
    tenyrPkg::word_t   insn;
    tenyrPkg::word_t   nextPc;
    tenyrPkg::word_t   aluResult;
    tenyrPkg::word_t   loadedData;
    tenyrPkg::word_t   nextZ;
    logic              execEnable;
    logic              execDone;
    tenyrPkg::word_t   execResult;

    tenyrPkg::regIdx_t zIndex;
    tenyrPkg::regIdx_t xIndex;
    tenyrPkg::regIdx_t yIndex;
    tenyrPkg::word_t   immediate;
    tenyrPkg::opcode_t op;
    tenyrPkg::kind_t   kind;
    logic              storing;
    logic              loading;
    logic              deref;
    logic              branching;
    tenyrPkg::word_t   zValue;
    tenyrPkg::word_t   xValue;
    tenyrPkg::word_t   yValue;
    tenyrPkg::word_t   operandA;
    tenyrPkg::word_t   operandB;
    tenyrPkg::word_t   operandC;
    logic              regWrite;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state      <= advance;
            instrAddr  <= tenyrPkg::RESET_VECTOR;
            insn       <= '0;
            execEnable <= 1'b0;
        end else begin
            execEnable <= 1'b0;
            case (state)
                fetchWait: begin
                    insn  <= instrData;
                    state <= issue;
                end
                issue: begin
                    if (halt) begin
                        insn <= instrData; // picks up words loaded while halted.
                    end else begin
                        execEnable <= 1'b1;
                        state      <= execute;
                    end
                end
                execute: begin
                    if (execDone) begin
                        state <= settle;
                    end
                end
                settle: begin
                    state <= memory; // data address reaches the RAM here.
                end
                memory: begin
                    if (!storing || storeReady) begin
                        state <= writeback;
                    end
                end
                writeback: begin
                    instrAddr <= branching ? nextZ : nextPc;
                    state     <= advance;
                end
                default: begin
                    state <= fetchWait;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == execute && execDone) begin
            aluResult <= execResult;
        end
        if (state == memory) begin
            loadedData <= dataIn;
        end
        if (state == advance) begin
            nextPc <= instrAddr + 1'b1;
        end
    end

    assign nextZ    = deref ? loadedData : aluResult;
    assign regWrite = (state == writeback) && !storing && !branching;

    assign dataStrobe = (state == memory) && (loading || storing);
    assign dataWrite  = storing;
    assign dataAddr   = aluResult;
    assign dataOut    = zValue;

    assign storeValid = (state == memory) && storing; // same cycle as the RAM write.
    assign storeAddr  = aluResult;
    assign storeData  = zValue;

    insnDecoder decoder (
        .insn      (insn),
        .zIndex    (zIndex),
        .xIndex    (xIndex),
        .yIndex    (yIndex),
        .immediate (immediate),
        .op        (op),
        .kind      (kind),
        .storing   (storing),
        .loading   (loading),
        .deref     (deref),
        .branching (branching)
    );

    operandRouter router (
        .clk       (clk),
        .reset_n   (reset_n),
        .kind      (kind),
        .xValue    (xValue),
        .yValue    (yValue),
        .immediate (immediate),
        .operandA  (operandA),
        .operandB  (operandB),
        .operandC  (operandC)
    );

    execUnit alu (
        .clk      (clk),
        .reset_n  (reset_n),
        .enable   (execEnable),
        .op       (op),
        .operandA (operandA),
        .operandB (operandB),
        .operandC (operandC),
        .done     (execDone),
        .result   (execResult)
    );

    registerFile regs (
        .clk         (clk),
        .writeEnable (regWrite),
        .zIndex      (zIndex),
        .xIndex      (xIndex),
        .yIndex      (yIndex),
        .writeData   (nextZ),
        .nextPc      (nextPc),
        .zValue      (zValue),
        .xValue      (xValue),
        .yValue      (yValue)
    );

    // a stalled store keeps its address and data until the trace takes it.
    storeHeld: assert property (@(posedge clk) disable iff (!reset_n)
        storeValid && !storeReady |=> storeValid && $stable(storeAddr) && $stable(storeData));

endmodule

// File: rtl/cpuSystem.sv
`timescale 1ns/1ps

module cpuSystem (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            halt,
    input  logic            loadValid,
    input  tenyrPkg::word_t loadAddr,
    input  tenyrPkg::word_t loadData,
    output logic            storeValid,
    input  logic            storeReady,
    output tenyrPkg::word_t storeAddr,
    output tenyrPkg::word_t storeData
);

    tenyrPkg::word_t instrAddr;
    tenyrPkg::word_t instrData;
    logic            dataStrobe;
    logic            dataWrite;
    tenyrPkg::word_t dataAddr;
    tenyrPkg::word_t dataIn;
    tenyrPkg::word_t dataOut;

    coreSequencer core (
        .clk        (clk),
        .reset_n    (reset_n),
        .halt       (halt),
        .instrAddr  (instrAddr),
        .instrData  (instrData),
        .dataStrobe (dataStrobe),
        .dataWrite  (dataWrite),
        .dataAddr   (dataAddr),
        .dataIn     (dataIn),
        .dataOut    (dataOut),
        .storeValid (storeValid),
        .storeReady (storeReady),
        .storeAddr  (storeAddr),
        .storeData  (storeData)
    );

    unifiedMemory ram (
        .clk        (clk),
        .instrAddr  (instrAddr),
        .instrData  (instrData),
        .dataStrobe (dataStrobe),
        .dataWrite  (dataWrite),
        .dataAddr   (dataAddr),
        .dataOut    (dataOut),
        .dataIn     (dataIn),
        .loadValid  (loadValid),
        .loadAddr   (loadAddr),
        .loadData   (loadData)
    );

endmodule

// File: rtl/execUnit.sv
`timescale 1ns/1ps

module execUnit (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              enable,
    input  tenyrPkg::opcode_t op,
    input  tenyrPkg::word_t   operandA,
    input  tenyrPkg::word_t   operandB,
    input  tenyrPkg::word_t   operandC,
    output logic              done,
    output tenyrPkg::word_t   result
);

    logic              valid1;
    logic              valid2;
    logic              valid3;
    tenyrPkg::opcode_t op1;
    tenyrPkg::word_t   a1;
    tenyrPkg::word_t   b1;
    tenyrPkg::word_t   c1;
    tenyrPkg::word_t   c2;
    tenyrPkg::word_t   y2;
    tenyrPkg::word_t   sum3;

    function automatic tenyrPkg::word_t aluOp(input tenyrPkg::opcode_t code,
                                              input tenyrPkg::word_t a,
                                              input tenyrPkg::word_t b);
        case (code)
            tenyrPkg::OP_OR:   return a | b;
            tenyrPkg::OP_AND:  return a & b;
            tenyrPkg::OP_ADD:  return a + b;
            tenyrPkg::OP_MUL:  return a * b;
            tenyrPkg::OP_SHL:  return a << b;
            tenyrPkg::OP_LT:   return {tenyrPkg::WORD_W{$signed(a) < $signed(b)}};
            tenyrPkg::OP_EQ:   return {tenyrPkg::WORD_W{a == b}};
            tenyrPkg::OP_GE:   return {tenyrPkg::WORD_W{$signed(a) >= $signed(b)}};
            tenyrPkg::OP_ANDN: return a & ~b;
            tenyrPkg::OP_XOR:  return a ^ b;
            tenyrPkg::OP_SUB:  return a - b;
            tenyrPkg::OP_XNOR: return a ~^ b;
            tenyrPkg::OP_SHR:  return a >> b;
            tenyrPkg::OP_NE:   return {tenyrPkg::WORD_W{a != b}};
            tenyrPkg::OP_SAR:  return tenyrPkg::word_t'($signed(a) >>> b);
            default:           return '0; // illegal opcode.
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            valid1 <= 1'b0;
            valid2 <= 1'b0;
            valid3 <= 1'b0;
            done   <= 1'b0;
        end else begin
            valid1 <= enable;
            valid2 <= valid1;
            valid3 <= valid2;
            done   <= valid3;
        end
    end

    always_ff @(posedge clk) begin
        op1    <= op;
        a1     <= operandA;
        b1     <= operandB;
        c1     <= operandC;
        y2     <= aluOp(op1, a1, b1);
        c2     <= c1; // C follows its operation down the pipe.
        sum3   <= y2 + c2;
        result <= sum3;
    end

    noIllegalOp: assert property (@(posedge clk) disable iff (!reset_n)
        valid1 |-> op1 != tenyrPkg::OP_ILLEGAL);

endmodule

// File: rtl/insnDecoder.sv
`timescale 1ns/1ps

module insnDecoder (
    input  tenyrPkg::word_t   insn,
    output tenyrPkg::regIdx_t zIndex,
    output tenyrPkg::regIdx_t xIndex,
    output tenyrPkg::regIdx_t yIndex,
    output tenyrPkg::word_t   immediate,
    output tenyrPkg::opcode_t op,
    output tenyrPkg::kind_t   kind,
    output logic              storing,
    output logic              loading,
    output logic              deref,
    output logic              branching
);

    logic [tenyrPkg::KIND_W-1:0]  kindBits;
    logic [tenyrPkg::STORE_W-1:0] storeBit;
    logic [tenyrPkg::DEREF_W-1:0] derefBit;
    logic [tenyrPkg::OP_W-1:0]    opBits;
    logic [tenyrPkg::IMM_W-1:0]   immBits;

    assign {kindBits, storeBit, derefBit, zIndex, xIndex, yIndex, opBits, immBits} = insn;

    assign kind      = tenyrPkg::kind_t'(kindBits);
    assign op        = tenyrPkg::opcode_t'(opBits);
    assign storing   = storeBit[0];
    assign deref     = derefBit[0];
    assign immediate = {{(tenyrPkg::WORD_W - tenyrPkg::IMM_W){immBits[tenyrPkg::IMM_W-1]}},
                        immBits};

    assign branching = (zIndex == tenyrPkg::PC_INDEX) && !storing; // any write to r15.
    assign loading   = deref && !storing;

endmodule

// File: rtl/operandRouter.sv
`timescale 1ns/1ps

module operandRouter (
    input  logic            clk,
    input  logic            reset_n,
    input  tenyrPkg::kind_t kind,
    input  tenyrPkg::word_t xValue,
    input  tenyrPkg::word_t yValue,
    input  tenyrPkg::word_t immediate,
    output tenyrPkg::word_t operandA,
    output tenyrPkg::word_t operandB,
    output tenyrPkg::word_t operandC
);

    always_comb begin
        case (kind)
            tenyrPkg::KIND_XYI: {operandA, operandB, operandC} = {xValue, yValue, immediate};
            tenyrPkg::KIND_XIY: {operandA, operandB, operandC} = {xValue, immediate, yValue};
            tenyrPkg::KIND_IXY: {operandA, operandB, operandC} = {immediate, xValue, yValue};
            default:            {operandA, operandB, operandC} = '0;
        endcase
    end

    noIllegalKind: assert property (@(posedge clk) disable iff (!reset_n)
        kind != tenyrPkg::KIND_ILLEGAL);

endmodule

// File: rtl/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic              clk,
    input  logic              writeEnable,
    input  tenyrPkg::regIdx_t zIndex,
    input  tenyrPkg::regIdx_t xIndex,
    input  tenyrPkg::regIdx_t yIndex,
    input  tenyrPkg::word_t   writeData,
    input  tenyrPkg::word_t   nextPc,
    output tenyrPkg::word_t   zValue,
    output tenyrPkg::word_t   xValue,
    output tenyrPkg::word_t   yValue
);

    tenyrPkg::word_t regs [1:14]; // r0 and the pc alias are not stored.

    assign zValue = (zIndex == '0) ? '0 :
                    (zIndex == tenyrPkg::PC_INDEX) ? nextPc : regs[zIndex];
    assign xValue = (xIndex == '0) ? '0 :
                    (xIndex == tenyrPkg::PC_INDEX) ? nextPc : regs[xIndex];
    assign yValue = (yIndex == '0) ? '0 :
                    (yIndex == tenyrPkg::PC_INDEX) ? nextPc : regs[yIndex];

    always_ff @(posedge clk) begin
        if (writeEnable && zIndex != '0 && zIndex != tenyrPkg::PC_INDEX) begin
            regs[zIndex] <= writeData;
        end
    end

    // branches go through the sequencer, never through the array.
    pcNeverWritten: assert property (@(posedge clk)
        writeEnable |-> zIndex != tenyrPkg::PC_INDEX);

endmodule

// File: rtl/tenyrPkg.sv
package tenyrPkg;

    localparam int WORD_W  = 32;
    localparam int KIND_W  = 2;
    localparam int STORE_W = 1;
    localparam int DEREF_W = 1;
    localparam int IDX_W   = 4;
    localparam int OP_W    = 4;
    localparam int IMM_W   = 12;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [IDX_W-1:0]  regIdx_t;

    typedef enum logic [OP_W-1:0] {
        OP_OR      = 4'd0,
        OP_AND     = 4'd1,
        OP_ADD     = 4'd2,
        OP_MUL     = 4'd3,
        OP_ILLEGAL = 4'd4,
        OP_SHL     = 4'd5,
        OP_LT      = 4'd6,
        OP_EQ      = 4'd7,
        OP_GE      = 4'd8,
        OP_ANDN    = 4'd9,
        OP_XOR     = 4'd10,
        OP_SUB     = 4'd11,
        OP_XNOR    = 4'd12,
        OP_SHR     = 4'd13,
        OP_NE      = 4'd14,
        OP_SAR     = 4'd15
    } opcode_t;

    // letters give the order of A, B and C.
    typedef enum logic [KIND_W-1:0] {
        KIND_XYI     = 2'd0,
        KIND_XIY     = 2'd1,
        KIND_IXY     = 2'd2,
        KIND_ILLEGAL = 2'd3
    } kind_t;

    localparam int      MEM_DEPTH    = 4096;
    localparam int      MEM_ADDR_W   = 12;
    localparam word_t   RESET_VECTOR = '0;
    localparam regIdx_t PC_INDEX     = 4'd15;

endpackage

// File: rtl/unifiedMemory.sv
`timescale 1ns/1ps

module unifiedMemory (
    input  logic            clk,
    input  tenyrPkg::word_t instrAddr,
    output tenyrPkg::word_t instrData,
    input  logic            dataStrobe,
    input  logic            dataWrite,
    input  tenyrPkg::word_t dataAddr,
    input  tenyrPkg::word_t dataOut,
    output tenyrPkg::word_t dataIn,
    input  logic            loadValid,
    input  tenyrPkg::word_t loadAddr,
    input  tenyrPkg::word_t loadData
);

    tenyrPkg::word_t mem [tenyrPkg::MEM_DEPTH];

    logic [tenyrPkg::MEM_ADDR_W-1:0] instrIdx;
    logic [tenyrPkg::MEM_ADDR_W-1:0] dataIdx;
    logic [tenyrPkg::MEM_ADDR_W-1:0] loadIdx;

    assign instrIdx = instrAddr[tenyrPkg::MEM_ADDR_W-1:0];
    assign dataIdx  = dataAddr[tenyrPkg::MEM_ADDR_W-1:0];
    assign loadIdx  = loadAddr[tenyrPkg::MEM_ADDR_W-1:0];

    // power-up contents decode as a harmless or into r0.
    initial begin
        for (int i = 0; i < tenyrPkg::MEM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        instrData <= mem[instrIdx]; // reads return the old word on a collision.
        dataIn    <= mem[dataIdx];
        if (dataStrobe && dataWrite) begin
            mem[dataIdx] <= dataOut;
        end else if (loadValid) begin
            mem[loadIdx] <= loadData;
        end
    end

endmodule

// File: src.f
rtl/tenyrPkg.sv
rtl/registerFile.sv
rtl/insnDecoder.sv
rtl/operandRouter.sv
rtl/execUnit.sv
rtl/coreSequencer.sv
rtl/unifiedMemory.sv
rtl/cpuSystem.sv
test/cpuSystemTb.sv

// File: test/cpuSystemTb.sv
`timescale 1ns/1ps

module cpuSystemTb;

    localparam int FILE_WORDS    = 256;
    localparam int STORE_TIMEOUT = 1000;
    localparam int QUIET_CYCLES  = 200;

    logic            clk;
    logic            reset_n;
    logic            halt;
    logic            loadValid;
    tenyrPkg::word_t loadAddr;
    tenyrPkg::word_t loadData;
    logic            storeValid;
    logic            storeReady;
    tenyrPkg::word_t storeAddr;
    tenyrPkg::word_t storeData;

    tenyrPkg::word_t fileWords [FILE_WORDS];
    int unsigned     seed;
    int              programLength;
    int              storeBase;
    int              storeCount;

    cpuSystem uut (
        .clk        (clk),
        .reset_n    (reset_n),
        .halt       (halt),
        .loadValid  (loadValid),
        .loadAddr   (loadAddr),
        .loadData   (loadData),
        .storeValid (storeValid),
        .storeReady (storeReady),
        .storeAddr  (storeAddr),
        .storeData  (storeData)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compareAddr(input string testName, input tenyrPkg::word_t expected,
                               input tenyrPkg::word_t actual);
        if (actual !== expected) begin
            abortRun($sformatf("Mismatch in %s: expected %h, actual %h",
                               testName, expected, actual));
        end
    endtask

    task automatic compareData(input string testName, input tenyrPkg::word_t expected,
                               input tenyrPkg::word_t actual);
        if (actual !== expected) begin
            abortRun($sformatf("Mismatch in %s: expected %h, actual %h",
                               testName, expected, actual));
        end
    endtask

    // writes the program into memory while the core sits halted in issue.
    task automatic loadProgram();
        for (int i = 0; i < programLength; i++) begin
            @(posedge clk);
            loadValid <= 1'b1;
            loadAddr  <= tenyrPkg::word_t'(i);
            loadData  <= fileWords[1 + i];
        end
        @(posedge clk);
        loadValid <= 1'b0;
    endtask

    // ready is redrawn every cycle and the handshake is sampled mid-cycle.
    task automatic waitForStore(input int index, output tenyrPkg::word_t addr,
                                output tenyrPkg::word_t data);
        int cycles;
        logic accepted;
        cycles   = 0;
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            storeReady <= ($urandom % 5) < 3;
            @(negedge clk);
            if (storeValid && storeReady) begin
                addr     = storeAddr;
                data     = storeData;
                accepted = 1'b1;
            end else begin
                cycles++;
                if (cycles > STORE_TIMEOUT) begin
                    abortRun($sformatf("No store %0d arrived within %0d cycles",
                                       index, STORE_TIMEOUT));
                end
            end
        end
    endtask

    // the program ends in a spin loop, so no further store may show up.
    task automatic checkQuiet();
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(posedge clk);
            storeReady <= ($urandom % 5) < 3;
            @(negedge clk);
            if (storeValid && storeReady) begin
                abortRun($sformatf("An unexpected store to %h appeared after the last one",
                                   storeAddr));
            end
        end
    endtask

    initial begin
        tenyrPkg::word_t gotAddr;
        tenyrPkg::word_t gotData;
        seed = 32'h23d0_4408;
        void'($urandom(seed));
        reset_n    = 1'b0;
        halt       = 1'b1;
        loadValid  = 1'b0;
        loadAddr   = '0;
        loadData   = '0;
        storeReady = 1'b0;

        $readmemh("test/programInput.txt", fileWords);
        if ($isunknown(fileWords[0])) begin
            abortRun("The program input file could not be read");
        end
        programLength = int'(fileWords[0]);
        storeBase     = 1 + programLength;
        storeCount    = int'(fileWords[storeBase]);

        repeat (16) @(posedge clk);
        reset_n <= 1'b1;

        loadProgram();
        repeat (4) @(posedge clk); // lets the first word reach the decoder.
        halt <= 1'b0;

        for (int k = 0; k < storeCount; k++) begin
            waitForStore(k, gotAddr, gotData);
            compareAddr($sformatf("store %0d address", k),
                        fileWords[storeBase + 1 + 2 * k], gotAddr);
            compareData($sformatf("store %0d data", k),
                        fileWords[storeBase + 2 + 2 * k], gotData);
        end
        checkQuiet();

        $display("Simulation passed");
        $finish;
    end

endmodule

// File: test/programInput.txt
// first value: program length, then the program words from address 0 upward.
// then the store count and one expected store address/data pair per store; all values in hex.
36
810005A3 82000F93 84000003
03120010 A3000100 03121010 A3000101   // or, and
03122010 A3000102 03123010 A3000103   // add, multiply
03145010 A3000104 03126010 A3000105   // shift left, less-than
03117010 A3000106 03128010 A3000107   // equal, greater-or-equal
03129010 A3000108 0312A010 A3000109   // and-not, xor
0312B010 A300010A 0312C010 A300010B   // subtract, xnor
0324D010 A300010C 0312E010 A300010D   // logical shift right, not-equal
0324F010 A300010E                     // arithmetic shift right
0312BF00 A3000110 4312BF00 A3000111   // kinds 0 and 1 with a negative immediate
8312BF00 A3000112                     // kind 2
95000103 A5000113                     // load the stored product back
80000123 A0000114                     // r0 ignores the write
06F00000 A6000115 AF000116            // r15 read as an operand
8F000031 A10001FF A10001FF A1000117   // absolute branch over two stores
0FF02001 A20001FF A2000118            // relative branch through r15
8F000035                              // spin in place
18
00000100 FFFFFFC3 00000101 00000593
00000102 00000546 00000103 FFFD99A9
00000104 00002D28 00000105 00000010
00000106 0000000F 00000107 0000000F
00000108 00000030 00000109 FFFFFA40
0000010A 00000620 0000010B 000005DF
0000010C 20000002 0000010D 0000000F
0000010E 00000002 00000110 00000510
00000111 00000636 00000112 FFFFF8F0
00000113 FFFD99A9 00000114 00000000
00000115 0000002C 00000116 0000002E
00000117 000005A3 00000118 FFFFFF93
